//--- common/flush_pkg.sv
package flush_pkg;

   localparam int LINE_ADDR_W  = 12;
   localparam int L1I_LG_LINES = 5;   // 32 lines
   localparam int L1D_LG_LINES = 4;   // 16 lines
   localparam int L2_LG_LINES  = 6;   // 64 lines

   localparam int L1D_TAG_W = LINE_ADDR_W - L1D_LG_LINES;
   localparam int L2_TAG_W  = LINE_ADDR_W - L2_LG_LINES;

   typedef struct packed {
      logic [L1D_TAG_W-1:0]    tag;
      logic [L1D_LG_LINES-1:0] idx;
   } l1d_line_t;

   typedef struct packed {
      logic [L2_TAG_W-1:0]    tag;
      logic [L2_LG_LINES-1:0] idx;
   } l2_line_t;

   // same line address, split for each cache geometry
   typedef union packed {
      l1d_line_t l1d;
      l2_line_t  l2;
   } line_addr_u;

   typedef enum logic [1:0] {
      SEL_L1I = 2'd0,
      SEL_L1D = 2'd1,
      SEL_L2  = 2'd2
   } cache_sel_e;

   typedef struct packed {
      logic       valid;
      cache_sel_e sel;
      line_addr_u addr;
   } mark_t;

   typedef struct packed {
      logic l1i;
      logic l1d;
   } flush_req_t;

   typedef enum logic [2:0] {
      FLUSH_IDLE       = 3'd0,
      WAIT_FOR_L1D_L1I = 3'd1,
      GOT_L1D          = 3'd2,
      GOT_L1I          = 3'd3,
      FLUSH_L2         = 3'd4
   } flush_state_e;

endpackage

//--- hw/flush_sequencer.sv
module flush_sequencer import flush_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  flush_req_t flush_req,
   input  logic       l1i_done,
   input  logic       l1d_done,
   input  logic       l2_done,
   output logic       start_l1i,
   output logic       start_l1d,
   output logic       start_l2,
   output logic       in_flush_mode
);

   flush_state_e r_state, n_state;
   logic         accept;
   logic         r_kick;   // one cycle after accept

   assign accept        = (r_state == FLUSH_IDLE) && (flush_req.l1i || flush_req.l1d);
   assign in_flush_mode = (r_state != FLUSH_IDLE);

   always_comb
   begin
      n_state = r_state;
      case (r_state)
         FLUSH_IDLE:
         begin
            if (flush_req.l1i && flush_req.l1d)
               n_state = WAIT_FOR_L1D_L1I;
            else if (flush_req.l1i)
               n_state = GOT_L1D;   // data side not requested
            else if (flush_req.l1d)
               n_state = GOT_L1I;
         end
         WAIT_FOR_L1D_L1I:
         begin
            if (l1d_done && l1i_done)
               n_state = FLUSH_L2;
            else if (l1d_done)
               n_state = GOT_L1D;
            else if (l1i_done)
               n_state = GOT_L1I;
         end
         GOT_L1D:
         begin
            if (l1i_done)
               n_state = FLUSH_L2;
         end
         GOT_L1I:
         begin
            if (l1d_done)
               n_state = FLUSH_L2;
         end
         FLUSH_L2:
         begin
            if (l2_done)
               n_state = FLUSH_IDLE;
         end
         default:
            n_state = FLUSH_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state   <= FLUSH_IDLE;
         r_kick    <= 1'b0;
         start_l1i <= 1'b0;
         start_l1d <= 1'b0;
         start_l2  <= 1'b0;
      end
      else
      begin
         r_state   <= n_state;
         r_kick    <= accept;
         start_l1i <= r_kick && (r_state == WAIT_FOR_L1D_L1I || r_state == GOT_L1D);
         start_l1d <= r_kick && (r_state == WAIT_FOR_L1D_L1I || r_state == GOT_L1I);
         start_l2  <= (n_state == FLUSH_L2) && (r_state != FLUSH_L2);
      end
   end

   // each walker reports done only in the phase that waits for it
   a_l1i_done_phase: assert property (@(posedge clk) disable iff (reset)
      l1i_done |-> (r_state == WAIT_FOR_L1D_L1I || r_state == GOT_L1D) && !start_l1i);

   a_l1d_done_phase: assert property (@(posedge clk) disable iff (reset)
      l1d_done |-> (r_state == WAIT_FOR_L1D_L1I || r_state == GOT_L1I) && !start_l1d);

   a_l2_done_phase: assert property (@(posedge clk) disable iff (reset)
      l2_done |-> r_state == FLUSH_L2 && !start_l2);

endmodule

//--- l1/l1i_cache.sv
module l1i_cache import flush_pkg::*;
(
   input  logic  clk,
   input  logic  reset,
   input  mark_t mark,
   input  logic  start,
   output logic  done
);

   logic [(1 << L1I_LG_LINES)-1:0] valid;
   logic                           busy;
   logic [L1I_LG_LINES-1:0]        idx;

   assign done = busy && (idx == '1);   // last index cleared this cycle

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         valid <= '0;
         busy  <= 1'b0;
         idx   <= '0;
      end
      else
      begin
         if (mark.valid && mark.sel == SEL_L1I)
            valid[mark.addr[L1I_LG_LINES-1:0]] <= 1'b1;
         if (start)
         begin
            busy <= 1'b1;
            idx  <= '0;
         end
         else if (busy)
         begin
            valid[idx] <= 1'b0;   // invalidate only, nothing to write back
            idx        <= idx + 1'b1;
            if (idx == '1)
               busy <= 1'b0;
         end
      end
   end

   a_walk_clears: assert property (@(posedge clk) disable iff (reset)
      done |=> valid == '0);

endmodule

//--- l1/l1d_cache.sv
module l1d_cache import flush_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  mark_t      mark,
   input  logic       start,
   input  logic       fill_ack,
   output logic       done,
   output logic       fill_req,
   output line_addr_u fill_addr
);

   logic [L1D_TAG_W-1:0]           tag_mem [1 << L1D_LG_LINES];
   logic [(1 << L1D_LG_LINES)-1:0] valid;
   logic [(1 << L1D_LG_LINES)-1:0] dirty;
   logic                           busy;
   logic [L1D_LG_LINES-1:0]        idx;
   logic                           line_dirty;
   logic                           advance;

   assign line_dirty = valid[idx] && dirty[idx];
   assign advance    = busy && (fill_req ? fill_ack : !line_dirty);
   assign done       = advance && (idx == '1);

   always_ff @(posedge clk)
   begin
      if (mark.valid && mark.sel == SEL_L1D)
         tag_mem[mark.addr.l1d.idx] <= mark.addr.l1d.tag;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         valid    <= '0;
         dirty    <= '0;
         busy     <= 1'b0;
         idx      <= '0;
         fill_req <= 1'b0;
      end
      else
      begin
         if (mark.valid && mark.sel == SEL_L1D)
         begin
            valid[mark.addr.l1d.idx] <= 1'b1;
            dirty[mark.addr.l1d.idx] <= 1'b1;
         end
         if (start)
         begin
            busy <= 1'b1;
            idx  <= '0;
         end
         else if (advance)
         begin
            valid[idx] <= 1'b0;
            dirty[idx] <= 1'b0;
            fill_req   <= 1'b0;
            idx        <= idx + 1'b1;
            if (idx == '1)
               busy <= 1'b0;
         end
         else if (busy && !fill_req && !fill_ack)
            fill_req <= 1'b1;   // dirty line, previous ack has dropped
      end
   end

   // rebuild the full line address from tag and index
   always_ff @(posedge clk)
   begin
      if (busy && !fill_req)
      begin
         fill_addr.l1d.tag <= tag_mem[idx];
         fill_addr.l1d.idx <= idx;
      end
   end

   // a raised request keeps naming the walked line until it is acked
   a_fill_addr_stable: assert property (@(posedge clk) disable iff (reset)
      fill_req |-> fill_addr.l1d.idx == idx && fill_addr.l1d.tag == tag_mem[idx]);

endmodule

//--- l2/l2_cache.sv
module l2_cache import flush_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  mark_t      mark,
   input  logic       start,
   input  logic       fill_req,
   input  line_addr_u fill_addr,
   input  logic       wb_ack,
   output logic       done,
   output logic       fill_ack,
   output logic       wb_req,
   output line_addr_u wb_addr
);

   logic [L2_TAG_W-1:0]           tag_mem [1 << L2_LG_LINES];
   logic [(1 << L2_LG_LINES)-1:0] valid;
   logic [(1 << L2_LG_LINES)-1:0] dirty;
   logic                          busy;   // flush walker active
   logic [L2_LG_LINES-1:0]        idx;
   logic                          line_dirty;
   logic                          advance;
   logic                          fill_pend;
   logic                          victim;
   logic                          install;
   logic                          wb_done;

   assign line_dirty = valid[idx] && dirty[idx];
   assign advance    = busy && !wb_req && !line_dirty;
   assign done       = advance && (idx == '1);

   assign fill_pend = fill_req && !fill_ack;
   assign victim    = valid[fill_addr.l2.idx] && dirty[fill_addr.l2.idx] &&
                      (tag_mem[fill_addr.l2.idx] != fill_addr.l2.tag);
   assign install   = fill_pend && !wb_req && !victim;
   assign wb_done   = wb_req && wb_ack;

   always_ff @(posedge clk)
   begin
      if (mark.valid && mark.sel == SEL_L2)
         tag_mem[mark.addr.l2.idx] <= mark.addr.l2.tag;
      else if (install)
         tag_mem[fill_addr.l2.idx] <= fill_addr.l2.tag;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         valid    <= '0;
         dirty    <= '0;
         busy     <= 1'b0;
         idx      <= '0;
         fill_ack <= 1'b0;
         wb_req   <= 1'b0;
      end
      else
      begin
         if (mark.valid && mark.sel == SEL_L2)
         begin
            valid[mark.addr.l2.idx] <= 1'b1;
            dirty[mark.addr.l2.idx] <= 1'b1;
         end

         if (install)
         begin
            valid[fill_addr.l2.idx] <= 1'b1;
            dirty[fill_addr.l2.idx] <= 1'b1;
            fill_ack                <= 1'b1;
         end
         else if (fill_ack && !fill_req)
            fill_ack <= 1'b0;

         // one memory write-back in flight, victim or flush
         if (wb_done)
         begin
            wb_req                <= 1'b0;
            valid[wb_addr.l2.idx] <= 1'b0;
            dirty[wb_addr.l2.idx] <= 1'b0;
         end
         else if (!wb_req && !wb_ack && ((fill_pend && victim) || (busy && line_dirty)))
            wb_req <= 1'b1;

         if (start)
         begin
            busy <= 1'b1;
            idx  <= '0;
         end
         else if (advance)
         begin
            valid[idx] <= 1'b0;
            dirty[idx] <= 1'b0;
            idx        <= idx + 1'b1;
            if (idx == '1)
               busy <= 1'b0;
         end
      end
   end

   // latched in the cycle wb_req rises
   always_ff @(posedge clk)
   begin
      if (!wb_req)
      begin
         if (busy)
         begin
            wb_addr.l2.tag <= tag_mem[idx];
            wb_addr.l2.idx <= idx;
         end
         else
         begin
            wb_addr.l2.tag <= tag_mem[fill_addr.l2.idx];
            wb_addr.l2.idx <= fill_addr.l2.idx;
         end
      end
   end

   a_no_mark_busy: assert property (@(posedge clk) disable iff (reset)
      mark.valid |-> !busy && !fill_req && !fill_ack);

   // write-back keeps naming a resident dirty line until memory acks
   a_wb_addr_stable: assert property (@(posedge clk) disable iff (reset)
      wb_req |-> valid[wb_addr.l2.idx] && dirty[wb_addr.l2.idx] &&
                 tag_mem[wb_addr.l2.idx] == wb_addr.l2.tag);

endmodule

//--- hw/cache_flush_top.sv
module cache_flush_top import flush_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  mark_t      mark,
   input  flush_req_t flush_req,
   output logic       in_flush_mode,
   output logic       wb_req,
   output line_addr_u wb_addr,
   input  logic       wb_ack
);

   logic       start_l1i;
   logic       start_l1d;
   logic       start_l2;
   logic       l1i_done;
   logic       l1d_done;
   logic       l2_done;
   logic       fill_req;
   logic       fill_ack;
   line_addr_u fill_addr;   // l1d write-back into l2

   flush_sequencer sequencer_i (
      .clk           (clk),
      .reset         (reset),
      .flush_req     (flush_req),
      .l1i_done      (l1i_done),
      .l1d_done      (l1d_done),
      .l2_done       (l2_done),
      .start_l1i     (start_l1i),
      .start_l1d     (start_l1d),
      .start_l2      (start_l2),
      .in_flush_mode (in_flush_mode)
   );

   l1i_cache l1i_i (
      .clk   (clk),
      .reset (reset),
      .mark  (mark),
      .start (start_l1i),
      .done  (l1i_done)
   );

   l1d_cache l1d_i (
      .clk       (clk),
      .reset     (reset),
      .mark      (mark),
      .start     (start_l1d),
      .fill_ack  (fill_ack),
      .done      (l1d_done),
      .fill_req  (fill_req),
      .fill_addr (fill_addr)
   );

   l2_cache l2_i (
      .clk       (clk),
      .reset     (reset),
      .mark      (mark),
      .start     (start_l2),
      .fill_req  (fill_req),
      .fill_addr (fill_addr),
      .wb_ack    (wb_ack),
      .done      (l2_done),
      .fill_ack  (fill_ack),
      .wb_req    (wb_req),
      .wb_addr   (wb_addr)
   );

endmodule

//--- testbench/cache_flush_model.svh
`ifndef CACHE_FLUSH_MODEL_SVH
`define CACHE_FLUSH_MODEL_SVH

// shadow tags and dirty bits of l1d and l2
logic [L1D_TAG_W-1:0]           m_l1d_tag [1 << L1D_LG_LINES];
logic [(1 << L1D_LG_LINES)-1:0] m_l1d_dirty;
logic [L2_TAG_W-1:0]            m_l2_tag [1 << L2_LG_LINES];
logic [(1 << L2_LG_LINES)-1:0]  m_l2_dirty;

function automatic void clear_model();
   m_l1d_dirty = '0;
   m_l2_dirty  = '0;
endfunction

function automatic void note_mark(input mark_t m);
   case (m.sel)
      SEL_L1D:
      begin
         m_l1d_tag[m.addr.l1d.idx]   = m.addr.l1d.tag;
         m_l1d_dirty[m.addr.l1d.idx] = 1'b1;
      end
      SEL_L2:
      begin
         m_l2_tag[m.addr.l2.idx]   = m.addr.l2.tag;   // last mark wins
         m_l2_dirty[m.addr.l2.idx] = 1'b1;
      end
      default:
         ;   // l1i lines never write back
   endcase
endfunction

// appends the memory write-backs of one flush to exp_q
function automatic void predict_flush(input flush_req_t req);
   line_addr_u a;
   line_addr_u v;
   int         i;
   if (req.l1d)
   begin
      for (i = 0; i < (1 << L1D_LG_LINES); i++)
      begin
         if (m_l1d_dirty[i])
         begin
            a.l1d.tag = m_l1d_tag[i];
            a.l1d.idx = i[L1D_LG_LINES-1:0];
            if (m_l2_dirty[a.l2.idx] && m_l2_tag[a.l2.idx] != a.l2.tag)
            begin
               v.l2.tag = m_l2_tag[a.l2.idx];   // victim leaves first
               v.l2.idx = a.l2.idx;
               exp_q.push_back(v);
            end
            m_l2_tag[a.l2.idx]   = a.l2.tag;
            m_l2_dirty[a.l2.idx] = 1'b1;
         end
      end
      m_l1d_dirty = '0;
   end
   if (req.l1i || req.l1d)
   begin
      for (i = 0; i < (1 << L2_LG_LINES); i++)
      begin
         if (m_l2_dirty[i])
         begin
            v.l2.tag = m_l2_tag[i];
            v.l2.idx = i[L2_LG_LINES-1:0];
            exp_q.push_back(v);
         end
      end
      m_l2_dirty = '0;
   end
endfunction

`endif

//--- testbench/cache_flush_tb.sv
module cache_flush_tb import flush_pkg::*;
();

   localparam int DRIVE_DLY     = 1;
   localparam int FLUSH_TIMEOUT = 4000;
   localparam flush_req_t FLUSH_L1D  = '{l1i: 1'b0, l1d: 1'b1};
   localparam flush_req_t FLUSH_L1I  = '{l1i: 1'b1, l1d: 1'b0};
   localparam flush_req_t FLUSH_BOTH = '{l1i: 1'b1, l1d: 1'b1};

   logic       clk;
   logic       reset;
   mark_t      mark;
   flush_req_t flush_req;
   logic       in_flush_mode;
   logic       wb_req;
   line_addr_u wb_addr;
   logic       wb_ack;

   integer     seed = 32'ha5e697fb;
   line_addr_u got_q[$];   // seen by memory, in order
   line_addr_u exp_q[$];
   string      cur_flush;
   event       check_ev;
   logic       check_done;

   `include "cache_flush_model.svh"

   cache_flush_top dut_i (
      .clk           (clk),
      .reset         (reset),
      .mark          (mark),
      .flush_req     (flush_req),
      .in_flush_mode (in_flush_mode),
      .wb_req        (wb_req),
      .wb_addr       (wb_addr),
      .wb_ack        (wb_ack)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #4 clk = ~clk;
   end

   task automatic value_error(input string msg);
      $display("** Error @ %0t: %s", $time, msg);
      $display("Done: errors found");
      $fatal(1, "simulation stopped");
   endtask

   task automatic timeout_error(input string what);
      flush_state_e st;
      st = dut_i.sequencer_i.r_state;
      $display("timeout while waiting for %s, sequencer in %s", what, st.name());
      $display("Done: errors found");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_addr(input line_addr_u got, input line_addr_u exp, input int n);
      if (got !== exp)
         value_error($sformatf("%s: write-back %0d went to %03h, expected %03h",
                               cur_flush, n, got, exp));
   endtask

   task automatic check_count(input int got, input int exp);
      if (got != exp)
         value_error($sformatf("%s: %0d write-backs, expected %0d", cur_flush, got, exp));
   endtask

   task automatic expect_flag(input logic got, input logic exp, input string what);
      if (got !== exp)
         value_error($sformatf("%s is %b, expected %b", what, got, exp));
   endtask

   function automatic int rand_below(input int n);
      logic [31:0] r;
      r = $random(seed);
      return int'(r % n);
   endfunction

   task automatic apply_mark(input cache_sel_e sel, input line_addr_u addr);
      mark_t m;
      m.valid = 1'b1;
      m.sel   = sel;
      m.addr  = addr;
      note_mark(m);
      mark = m;
      @(posedge clk);
      #DRIVE_DLY;
      mark = '0;
   endtask

   task automatic wait_flush_mode(input logic level, input int limit, input string what);
      int n;
      n = 0;
      while (in_flush_mode !== level)
      begin
         @(posedge clk);
         #DRIVE_DLY;
         n++;
         if (n > limit)
            timeout_error(what);
      end
   endtask

   task automatic run_flush(input flush_req_t req, input string what);
      int n;
      cur_flush = what;
      predict_flush(req);
      flush_req = req;
      @(posedge clk);
      #DRIVE_DLY;
      flush_req = '0;
      wait_flush_mode(1'b1, 4, {what, " to raise in_flush_mode"});
      wait_flush_mode(1'b0, FLUSH_TIMEOUT, {what, " to finish"});
      check_done = 1'b0;
      -> check_ev;
      n = 0;
      while (!check_done)
      begin
         @(posedge clk);
         #DRIVE_DLY;
         n++;
         if (n > 4)
            timeout_error("the compare process");
      end
   endtask

   task automatic random_round(input int round);
      int n_marks;
      int k;
      n_marks = rand_below(25);
      for (k = 0; k < n_marks; k++)
         apply_mark(cache_sel_e'(2'(rand_below(3))), LINE_ADDR_W'(rand_below(512)));
      run_flush(flush_req_t'(2'(rand_below(3) + 1)), $sformatf("random round %0d", round));
   endtask

   // memory side of the write-back handshake
   initial
   begin
      int delay;
      int n;
      wb_ack = 1'b0;
      forever
      begin
         @(posedge clk);
         #DRIVE_DLY;
         if (wb_req)
         begin
            got_q.push_back(wb_addr);
            delay = rand_below(4);
            repeat (delay)
            begin
               @(posedge clk);
               #DRIVE_DLY;
            end
            wb_ack = 1'b1;
            n = 0;
            while (wb_req)
            begin
               @(posedge clk);
               #DRIVE_DLY;
               n++;
               if (n > 8)
                  timeout_error("wb_req to drop after wb_ack");
            end
            wb_ack = 1'b0;
         end
      end
   end

   initial
   begin
      int i;
      forever
      begin
         @(check_ev);
         check_count(got_q.size(), exp_q.size());
         for (i = 0; i < exp_q.size(); i++)
            check_addr(got_q[i], exp_q[i], i);
         got_q.delete();
         exp_q.delete();
         check_done = 1'b1;
      end
   end

   initial
   begin
      int r;
      mark       = '0;
      flush_req  = '0;
      reset      = 1'b1;
      check_done = 1'b0;
      clear_model();
      repeat (4) @(posedge clk);
      #DRIVE_DLY;
      reset = 1'b0;
      expect_flag(in_flush_mode, 1'b0, "in_flush_mode after reset");
      expect_flag(wb_req, 1'b0, "wb_req after reset");
      run_flush(FLUSH_BOTH, "empty flush");

      apply_mark(SEL_L2, 12'h0c5);
      apply_mark(SEL_L2, 12'h101);
      apply_mark(SEL_L2, 12'h245);   // same l2 index as 0c5
      run_flush(FLUSH_L1D, "l2 marks only");

      apply_mark(SEL_L2, 12'h043);
      apply_mark(SEL_L2, 12'h1e7);
      apply_mark(SEL_L1D, 12'h083);   // evicts 043
      apply_mark(SEL_L1D, 12'h1e7);   // same tag, no victim
      apply_mark(SEL_L1D, 12'h00a);
      run_flush(FLUSH_BOTH, "l1d through l2");

      apply_mark(SEL_L2, 12'h210);
      apply_mark(SEL_L1D, 12'h0a7);
      apply_mark(SEL_L1I, 12'h01f);
      run_flush(FLUSH_L1I, "l1i only");
      run_flush(FLUSH_L1D, "l1d after l1i");
      run_flush(FLUSH_BOTH, "back to back");

      for (r = 0; r < 12; r++)
         random_round(r);

      $display("Done: no errors");
      $finish;
   end

endmodule

//--- cache_flush.f
+incdir+testbench
common/flush_pkg.sv
hw/flush_sequencer.sv
l1/l1i_cache.sv
l1/l1d_cache.sv
l2/l2_cache.sv
hw/cache_flush_top.sv
testbench/cache_flush_tb.sv

//--- Bender.yml
package:
  name: cache_flush

sources:
  - files:
      - common/flush_pkg.sv
      - hw/flush_sequencer.sv
      - l1/l1i_cache.sv
      - l1/l1d_cache.sv
      - l2/l2_cache.sv
      - hw/cache_flush_top.sv

  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/cache_flush_tb.sv
